//--- src/rv8u_defs.svh
////////////////////////////////////////////////////////////
// widths and instruction field positions for the rv8u slice
// included by the package and by any file using the macros
////////////////////////////////////////////////////////////

`ifndef RV8U_DEFS_SVH
`define RV8U_DEFS_SVH

// datapath and instruction widths
`define RV8U_XLEN 8
`define RV8U_ILEN 16
`define RV8U_RBITS 3
// rs2 reaches x0..x3 only
`define RV8U_RS2_BITS 2

// 16-bit instruction fields
`define RV8U_OPC_HI 2
`define RV8U_OPC_LO 0
`define RV8U_RD_HI 5
`define RV8U_RD_LO 3
`define RV8U_F3_HI 8
`define RV8U_F3_LO 6
`define RV8U_RS1_HI 11
`define RV8U_RS1_LO 9
`define RV8U_RS2_HI 13
`define RV8U_RS2_LO 12
// i-type immediate, bit 15 doubles as its sign
`define RV8U_IMM_HI 15
`define RV8U_IMM_LO 12
`define RV8U_ALT_BIT 15
// lui payload
`define RV8U_UIMM_HI 10
`define RV8U_UIMM_LO 6

`endif

//--- src/rv8u_pkg.sv
////////////////////////////////////////////////////////////
// shared types for the rv8u execute slice
// imported by wildcard in every rtl module header
////////////////////////////////////////////////////////////

`include "rv8u_defs.svh"

package rv8u_pkg;

	// data word, instruction and register index
	typedef logic [`RV8U_XLEN-1:0] word_t;
	typedef logic [`RV8U_ILEN-1:0] instr_t;
	typedef logic [`RV8U_RBITS-1:0] reg_idx_t;

	// opcode field, bits 2..0
	// system with funct3 0 is halt, other funct3 is the load/store class
	// values not listed here decode as no-ops
	typedef enum logic [2:0] {
		opc_system = 3'b000,
		opc_op_imm = 3'b001,
		opc_op = 3'b011,
		opc_lui = 3'b111
	} opcode_e;

	// alu op, upper bit is the alternate form, low bits follow funct3
	typedef enum logic [3:0] {
		alu_add = 4'b0000,
		alu_sll = 4'b0001,
		alu_slt = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor = 4'b0100,
		alu_srl = 4'b0101,
		alu_or = 4'b0110,
		alu_and = 4'b0111,
		alu_sub = 4'b1000,
		alu_sra = 4'b1101
	} alu_op_e;

endpackage

//--- src/rv8u_ifs.sv
////////////////////////////////////////////////////////////
// decoded-instruction bus and register read port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rv8u_defs.svh"

// decode to execute, one strobe per instruction
interface decoded_if
	import rv8u_pkg::*;
();
	logic valid;
	alu_op_e alu_op;
	reg_idx_t rd;
	reg_idx_t rs1;
	logic [`RV8U_RS2_BITS-1:0] rs2;
	// sign-extended imm, or the raw lui field
	word_t imm;
	logic use_imm;
	logic is_lui;
	// only op, op_imm and lui write back
	logic writes;

	modport source (output valid, alu_op, rd, rs1, rs2, imm, use_imm, is_lui, writes);
	modport sink (input valid, alu_op, rd, rs1, rs2, imm, use_imm, is_lui, writes);
endinterface

// execute asks, register file answers in the same cycle
interface reg_read_if
	import rv8u_pkg::*;
();
	reg_idx_t rs1;
	logic [`RV8U_RS2_BITS-1:0] rs2;
	word_t rs1_data;
	word_t rs2_data;

	modport reader (output rs1, rs2, input rs1_data, rs2_data);
	modport file (input rs1, rs2, output rs1_data, rs2_data);
endinterface

//--- src/rv8u_decode.sv
////////////////////////////////////////////////////////////
// decode stage, one register stage from host strobe to bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rv8u_defs.svh"

module rv8u_decode
	import rv8u_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input instr_t in_instr,
	output logic halted,
	decoded_if.source dec
);

	opcode_e opcode;
	logic [2:0] funct3;
	logic alt;
	logic accept;
	logic is_op;
	logic is_op_imm;
	logic is_lui;
	logic is_halt;
	alu_op_e alu_op;
	word_t imm;

	// field split
	assign opcode = opcode_e'(in_instr[`RV8U_OPC_HI:`RV8U_OPC_LO]);
	assign funct3 = in_instr[`RV8U_F3_HI:`RV8U_F3_LO];
	assign alt = in_instr[`RV8U_ALT_BIT];

	// strobes dropped once halted
	assign accept = in_valid & ~halted;
	assign is_op = (opcode == opc_op);
	assign is_op_imm = (opcode == opc_op_imm);
	assign is_lui = (opcode == opc_lui);
	assign is_halt = accept && (opcode == opc_system) && (funct3 == 3'b000);

	////////////////////////////////////////////////////////////
	// alu op and immediate

	always_comb begin
		case (funct3)
			3'b000: alu_op = (is_op && alt) ? alu_sub : alu_add;
			3'b001: alu_op = alu_sll;
			3'b010: alu_op = alu_slt;
			3'b011: alu_op = alu_sltu;
			3'b100: alu_op = alu_xor;
			// alt picks sra in both op and op_imm
			3'b101: alu_op = alt ? alu_sra : alu_srl;
			3'b110: alu_op = alu_or;
			default: alu_op = alu_and;
		endcase
	end

	always_comb begin
		if (is_lui)
			imm = word_t'(in_instr[`RV8U_UIMM_HI:`RV8U_UIMM_LO]);
		else
			imm = {{(`RV8U_XLEN - (`RV8U_IMM_HI - `RV8U_IMM_LO + 1)){in_instr[`RV8U_IMM_HI]}},
				in_instr[`RV8U_IMM_HI:`RV8U_IMM_LO]};
	end

	////////////////////////////////////////////////////////////
	// stage register and halt latch

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dec.valid <= 1'b0;
			halted <= 1'b0;
		end else begin
			dec.valid <= accept;
			// sticky until reset
			if (is_halt)
				halted <= 1'b1;
		end
	end

	// payload only, qualified by valid downstream
	always_ff @(posedge clk) begin
		if (accept) begin
			dec.alu_op <= alu_op;
			dec.rd <= in_instr[`RV8U_RD_HI:`RV8U_RD_LO];
			dec.rs1 <= in_instr[`RV8U_RS1_HI:`RV8U_RS1_LO];
			dec.rs2 <= in_instr[`RV8U_RS2_HI:`RV8U_RS2_LO];
			dec.imm <= imm;
			dec.use_imm <= is_op_imm;
			dec.is_lui <= is_lui;
			dec.writes <= is_op | is_op_imm | is_lui;
		end
	end

endmodule

//--- src/rv8u_execute.sv
////////////////////////////////////////////////////////////
// execute stage, 8-bit alu and lui, registered writeback
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rv8u_defs.svh"

module rv8u_execute
	import rv8u_pkg::*;
(
	input logic clk,
	input logic rst,
	decoded_if.sink dec,
	reg_read_if.reader rd_port,
	output logic wb_valid,
	output reg_idx_t wb_rd,
	output word_t wb_data
);

	word_t arg0;
	word_t arg1;
	word_t diff;
	word_t srl_res;
	word_t sra_mask;
	logic [4:0] shamt;
	word_t alu_res;
	word_t res;

	////////////////////////////////////////////////////////////
	// operands

	// indices go straight out, data comes back same cycle
	assign rd_port.rs1 = dec.rs1;
	assign rd_port.rs2 = dec.rs2;

	assign arg0 = rd_port.rs1_data;
	assign arg1 = dec.use_imm ? dec.imm : rd_port.rs2_data;

	////////////////////////////////////////////////////////////
	// alu

	// five shift bits, so 8 and up clears sll/srl
	assign shamt = arg1[4:0];
	assign diff = arg0 - arg1;
	assign srl_res = arg0 >> shamt;

	// sra fill, top arg1[2:0] bits when arg0 negative
	always_comb begin
		if (arg0[`RV8U_XLEN-1])
			sra_mask = ~({`RV8U_XLEN{1'b1}} >> arg1[2:0]);
		else
			sra_mask = '0;
	end

	always_comb begin
		case (dec.alu_op)
			alu_add: alu_res = arg0 + arg1;
			alu_sub: alu_res = diff;
			alu_sll: alu_res = arg0 << shamt;
			// sign of the difference, no overflow fixup
			alu_slt: alu_res = word_t'(diff[`RV8U_XLEN-1]);
			alu_sltu: alu_res = word_t'(arg0 < arg1);
			alu_xor: alu_res = arg0 ^ arg1;
			alu_srl: alu_res = srl_res;
			alu_sra: alu_res = srl_res | sra_mask;
			alu_or: alu_res = arg0 | arg1;
			alu_and: alu_res = arg0 & arg1;
			default: alu_res = '0;
		endcase
	end

	// lui: 5-bit field above three zeros
	assign res = dec.is_lui ? {dec.imm[4:0], 3'b000} : alu_res;

	////////////////////////////////////////////////////////////
	// writeback register

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= dec.valid & dec.writes;
	end

	// halt and no-op classes leave rd/data alone
	always_ff @(posedge clk) begin
		if (dec.valid && dec.writes) begin
			wb_rd <= dec.rd;
			wb_data <= res;
		end
	end

endmodule

//--- src/rv8u_result.sv
////////////////////////////////////////////////////////////
// register file x1..x7 with writeback and read forwarding
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv8u_result
	import rv8u_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic wb_valid,
	input reg_idx_t wb_rd,
	input word_t wb_data,
	reg_read_if.file rd_port
);

	// x0 has no storage
	word_t regs [1:7];

	// zero reg first, then the value being written this cycle
	function automatic word_t read_reg(input reg_idx_t idx);
		word_t val;
		if (idx == '0)
			val = '0;
		else if (wb_valid && (idx == wb_rd))
			val = wb_data;
		else
			val = regs[idx];
		return val;
	endfunction

	////////////////////////////////////////////////////////////
	// read ports

	always_comb begin
		rd_port.rs1_data = read_reg(rd_port.rs1);
		// rs2 only two bits wide, x0..x3
		rd_port.rs2_data = read_reg(reg_idx_t'(rd_port.rs2));
	end

	////////////////////////////////////////////////////////////
	// write port

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 1; i < 8; i++)
				regs[i] <= '0;
		end else if (wb_valid && (wb_rd != '0)) begin
			// writes to x0 dropped here
			regs[wb_rd] <= wb_data;
		end
	end

endmodule

//--- src/rv8u_top.sv
////////////////////////////////////////////////////////////
// rv8u execute slice, decode -> execute -> result
// host drives one instruction per in_valid strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv8u_top
	import rv8u_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input instr_t in_instr,
	output logic wb_valid,
	output reg_idx_t wb_rd,
	output word_t wb_data,
	output logic halted
);

	// stage buses
	decoded_if dec_bus ();
	reg_read_if rd_bus ();

	rv8u_decode u_decode (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.halted (halted),
		.dec (dec_bus.source)
	);

	// writeback also leaves the top
	rv8u_execute u_execute (
		.clk (clk),
		.rst (rst),
		.dec (dec_bus.sink),
		.rd_port (rd_bus.reader),
		.wb_valid (wb_valid),
		.wb_rd (wb_rd),
		.wb_data (wb_data)
	);

	rv8u_result u_result (
		.clk (clk),
		.rst (rst),
		.wb_valid (wb_valid),
		.wb_rd (wb_rd),
		.wb_data (wb_data),
		.rd_port (rd_bus.file)
	);

endmodule

//--- bench/rv8u_tb.sv
////////////////////////////////////////////////////////////
// testbench for rv8u_top, random instructions vs a reference model
// writebacks are checked in order against a queue of expected results
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv8u_tb;

	logic clk;
	logic rst;
	logic in_valid;
	logic [15:0] in_instr;
	logic wb_valid;
	logic [2:0] wb_rd;
	logic [7:0] wb_data;
	logic halted;

	int seed;
	int errors;
	int checks;
	string test_name;
	// model register file, x0 kept at zero
	logic [7:0] model [0:7];
	logic model_halted;
	// {rd, data} per expected writeback
	logic [10:0] exp_q [$];
	logic [10:0] exp_head;

	rv8u_top u_dut (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.wb_valid (wb_valid),
		.wb_rd (wb_rd),
		.wb_data (wb_data),
		.halted (halted)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reference model

	// returns {writes, rd, value}
	function automatic logic [11:0] ref_model(input logic [7:0] rf [0:7], input logic [15:0] ins);
		logic [2:0] opc;
		logic [2:0] f3;
		logic [2:0] rd;
		logic [2:0] rs1;
		logic [2:0] rs2;
		logic alt;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] diff;
		logic [7:0] mask;
		logic [7:0] val;
		opc = ins[2:0];
		rd = ins[5:3];
		f3 = ins[8:6];
		rs1 = ins[11:9];
		rs2 = {1'b0, ins[13:12]};
		alt = ins[15];
		a = (rs1 == 3'd0) ? 8'h00 : rf[rs1];
		b = (rs2 == 3'd0) ? 8'h00 : rf[rs2];
		val = 8'h00;
		if (opc == 3'b111)
			return {1'b1, rd, ins[10:6], 3'b000};
		if (opc != 3'b011 && opc != 3'b001)
			return {1'b0, rd, 8'h00};
		// op_imm: 4-bit field, bit 15 is its sign
		if (opc == 3'b001)
			b = {{4{ins[15]}}, ins[15:12]};
		diff = a - b;
		// fill bits for sra, top b[2:0] positions
		mask = 8'h00;
		for (int i = 0; i < 8; i++) begin
			if (a[7] && i >= 8 - int'(b[2:0]))
				mask[i] = 1'b1;
		end
		case (f3)
			3'b000: val = (opc == 3'b011 && alt) ? diff : a + b;
			3'b001: val = a << b[4:0];
			3'b010: val = {7'b0, diff[7]};
			3'b011: val = {7'b0, a < b};
			3'b100: val = a ^ b;
			3'b101: val = alt ? ((a >> b[4:0]) | mask) : (a >> b[4:0]);
			3'b110: val = a | b;
			default: val = a & b;
		endcase
		return {1'b1, rd, val};
	endfunction

	////////////////////////////////////////////////////////////
	// checks and compare process

	task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s: expected %02h actual %02h", test_name, what, exp, act);
		end
	endtask

	// outputs settle after posedge, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && wb_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("unexpected writeback in %s: rd %0d data %02h", test_name, wb_rd, wb_data);
			end else begin
				exp_head = exp_q.pop_front();
				check_value("wb_rd", {5'b0, exp_head[10:8]}, {5'b0, wb_rd});
				check_value("wb_data", exp_head[7:0], wb_data);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// drivers

	task automatic send(input logic [15:0] ins);
		logic [11:0] r;
		@(negedge clk);
		in_valid = 1'b1;
		in_instr = ins;
		if (!model_halted) begin
			r = ref_model(model, ins);
			if (r[11]) begin
				exp_q.push_back(r[10:0]);
				if (r[10:8] != 3'd0)
					model[r[10:8]] = r[7:0];
			end
			// halt, system class with funct3 zero
			if (ins[2:0] == 3'b000 && ins[8:6] == 3'b000)
				model_halted = 1'b1;
		end
	endtask

	// random junk on in_instr while idle
	task automatic idle(input int n);
		int r;
		repeat (n) begin
			@(negedge clk);
			r = $random(seed);
			in_valid = 1'b0;
			in_instr = r[15:0];
		end
	endtask

	task automatic rand_ins(input logic [2:0] opc, output logic [15:0] ins);
		int r;
		r = $random(seed);
		ins = {r[15:3], opc};
	endtask

	task automatic rand_gap(output int gap);
		int r;
		r = $random(seed);
		gap = {30'b0, r[1:0]};
	endtask

	task automatic drain();
		int i;
		i = 0;
		while (exp_q.size() != 0 && i < 40) begin
			idle(1);
			i++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%s: %0d expected writebacks never arrived", test_name, exp_q.size());
			exp_q.delete();
		end
		idle(2);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		logic [15:0] ins;
		logic [2:0] prev_rd;
		int gap;
		int r;
		int i;
		seed = 30;
		errors = 0;
		checks = 0;
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_instr = 16'h0000;
		model_halted = 1'b0;
		for (int k = 0; k < 8; k++)
			model[k] = 8'h00;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		test_name = "reset";
		@(negedge clk);
		check_value("wb_valid", 8'h00, {7'b0, wb_valid});
		check_value("halted", 8'h00, {7'b0, halted});
		// add x1 = x2 + x0, all zero out of reset
		send({4'b0000, 3'd2, 3'b000, 3'd1, 3'b011});
		drain();

		test_name = "imm_lui";
		for (int k = 0; k < 60; k++) begin
			r = $random(seed);
			rand_ins(r[0] ? 3'b111 : 3'b001, ins);
			send(ins);
			rand_gap(gap);
			idle(gap);
		end
		// x0 write shows on the bus, then reads back zero
		send({5'b0, 5'h1f, 3'd0, 3'b111});
		send({4'b0000, 3'd0, 3'b000, 3'd3, 3'b011});
		drain();

		test_name = "reg_reg";
		for (int k = 0; k < 200; k++) begin
			rand_ins(3'b011, ins);
			send(ins);
			rand_gap(gap);
			idle(gap);
		end
		drain();

		test_name = "forward";
		prev_rd = 3'd1;
		for (int k = 0; k < 100; k++) begin
			r = $random(seed);
			rand_ins(r[0] ? 3'b011 : 3'b001, ins);
			ins[11:9] = prev_rd;
			if (ins[2:0] == 3'b011 && prev_rd <= 3'd3)
				ins[13:12] = prev_rd[1:0];
			if (ins[5:3] == 3'd0)
				ins[5:3] = 3'd1;
			send(ins);
			prev_rd = ins[5:3];
		end
		drain();

		test_name = "noop";
		for (int k = 0; k < 40; k++) begin
			r = $random(seed);
			case (r[1:0])
				2'd0: rand_ins(3'b010, ins);
				2'd1: rand_ins(3'b100, ins);
				2'd2: rand_ins(3'b101, ins);
				default: rand_ins(3'b110, ins);
			endcase
			send(ins);
			// load/store class, system with nonzero funct3
			rand_ins(3'b000, ins);
			if (ins[8:6] == 3'b000)
				ins[8:6] = 3'b010;
			send(ins);
		end
		rand_ins(3'b011, ins);
		send(ins);
		drain();

		test_name = "halt";
		send(16'h0000);
		idle(1);
		i = 0;
		while (!halted && i < 20) begin
			idle(1);
			i++;
		end
		if (!halted) begin
			errors++;
			$display("halt: halted never went high");
		end
		for (int k = 0; k < 10; k++) begin
			rand_ins(3'b011, ins);
			send(ins);
		end
		// any writeback here trips the compare process
		idle(20);
		check_value("halted", 8'h01, {7'b0, halted});
		drain();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- list.f
+incdir+src
src/rv8u_pkg.sv
src/rv8u_ifs.sv
src/rv8u_decode.sv
src/rv8u_execute.sv
src/rv8u_result.sv
src/rv8u_top.sv
bench/rv8u_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rv8u testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module rv8u_tb -o rv8u_sim

out=$(./obj_dir/rv8u_sim)
echo "$out"

echo "$out" | grep -qx "Finished with no errors"
